// File: src/vc_bridge_pkg.sv
// bridge widths, channel enum, credit and payload types, packet struct and strobe values
package vc_bridge_pkg;

  // data widths; the wide width is also the packet data width
  localparam int NarrowWidth = 32;
  localparam int WideWidth   = 64;

  // credit field width and credits per channel
  localparam int CredWidth       = 4;
  localparam int NumCred         = 8;
  localparam int ForceSendThresh = 4;

  // virtual channel header
  typedef enum logic {
    chan_narrow = 1'b0,
    chan_wide   = 1'b1
  } chan_e;

  typedef logic [CredWidth-1:0]   credit_t;
  typedef logic [NarrowWidth-1:0] narrow_data_t;
  typedef logic [WideWidth-1:0]   wide_data_t;

  // one packet on the serial stream, 71 bits
  // narrow data sits zero-extended in the low word
  typedef struct packed {
    chan_e      data_hdr;
    wide_data_t data;
    logic       data_valid;
    chan_e      cred_hdr;
    credit_t    credits;
  } bridge_pkt_t;

  // byte strobes per channel
  localparam logic [WideWidth/8-1:0] NarrowStrb = 8'h0F;
  localparam logic [WideWidth/8-1:0] WideStrb   = 8'hFF;

endpackage

// File: src/vc_pkt_if.sv
`timescale 1ns/1ns
// valid/ready link carrying one bridge packet between pipeline stages
interface vc_pkt_if;
  import vc_bridge_pkg::*;

  logic        valid;
  logic        ready;
  bridge_pkt_t pkt;

  // producer side
  modport src (
    output valid,
    output pkt,
    input  ready
  );

  // consumer side
  modport dst (
    input  valid,
    input  pkt,
    output ready
  );

endinterface

// File: src/vc_credit_tracker.sv
`timescale 1ns/1ns
// per-channel remote credit counter, pending credit-return counter and send gate
module vc_credit_tracker #(
  parameter type data_t          = logic,
  parameter int  NumCred         = vc_bridge_pkg::NumCred,
  parameter int  ForceSendThresh = vc_bridge_pkg::ForceSendThresh
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // local flits
  input  logic                   valid_i,
  output logic                   ready_o,
  input  data_t                  data_i,
  // towards the arbiter
  output logic                   send_valid_o,
  input  logic                   send_ready_i,
  output data_t                  data_o,
  output logic                   cred_only_o,
  // credits coming back from the remote side
  input  logic                   cred_rx_valid_i,
  input  vc_bridge_pkg::credit_t cred_rx_i,
  // pops of the local receive queue
  input  logic                   pop_i,
  output vc_bridge_pkg::credit_t pending_o,
  input  logic                   pending_take_i
);
  import vc_bridge_pkg::*;

  credit_t credits_q;
  credit_t credits_d;
  credit_t pending_q;
  credit_t pending_d;
  logic    has_cred;
  logic    data_fire;

  //////////////////////////////////////////////////
  // send gate

  assign has_cred = (credits_q != '0);

  // data may only leave while the remote queue has room
  assign ready_o   = send_ready_i & has_cred;
  assign data_fire = valid_i & ready_o;

  // credits-only packet when returns pile up and no data can go
  assign cred_only_o  = ~(valid_i & has_cred) &
                        (pending_q >= credit_t'(ForceSendThresh));
  assign send_valid_o = (valid_i & has_cred) | cred_only_o;
  assign data_o       = data_i;
  assign pending_o    = pending_q;

  //////////////////////////////////////////////////
  // counters

  always_comb begin
    credits_d = credits_q;
    if (data_fire) begin
      credits_d = credits_d - credit_t'(1);
    end
    if (cred_rx_valid_i) begin
      credits_d = credits_d + cred_rx_i;
    end
  end

  // a pop in the take cycle is kept for the next report
  always_comb begin
    pending_d = pending_take_i ? '0 : pending_q;
    if (pop_i) begin
      pending_d = pending_d + credit_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_q <= credit_t'(NumCred);
      pending_q <= '0;
    end else begin
      credits_q <= credits_d;
      pending_q <= pending_d;
    end
  end

endmodule

// File: src/vc_tx_arbiter.sv
`timescale 1ns/1ns
// credit channel selection and narrow-over-wide arbitration into one bridge packet
module vc_tx_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  // narrow source
  input  logic                        narrow_valid_i,
  output logic                        narrow_ready_o,
  input  vc_bridge_pkg::narrow_data_t narrow_data_i,
  input  logic                        narrow_cred_only_i,
  input  vc_bridge_pkg::credit_t      narrow_pending_i,
  output logic                        narrow_take_o,
  // wide source
  input  logic                        wide_valid_i,
  output logic                        wide_ready_o,
  input  vc_bridge_pkg::wide_data_t   wide_data_i,
  input  logic                        wide_cred_only_i,
  input  vc_bridge_pkg::credit_t      wide_pending_i,
  output logic                        wide_take_o,
  // packet out
  vc_pkt_if.src                       out
);
  import vc_bridge_pkg::*;

  chan_e sel_q;
  chan_e sel_d;
  chan_e cred_sel;
  logic  hold_wide;
  logic  use_wide;
  logic  fire;

  // larger pending count wins, ties go to narrow
  assign cred_sel = (wide_pending_i > narrow_pending_i) ? chan_wide : chan_narrow;

  // narrow has priority unless a wide packet is already being presented
  assign hold_wide = (sel_q == chan_wide) & wide_valid_i;
  assign use_wide  = hold_wide | ~narrow_valid_i;

  assign out.valid      = use_wide ? wide_valid_i : narrow_valid_i;
  assign narrow_ready_o = ~hold_wide & out.ready;
  assign wide_ready_o   = use_wide & out.ready;
  assign fire           = out.valid & out.ready;

  // pending credits are consumed with the packet that carries them
  assign narrow_take_o = fire & (cred_sel == chan_narrow);
  assign wide_take_o   = fire & (cred_sel == chan_wide);

  always_comb begin
    out.pkt.data_hdr   = use_wide ? chan_wide : chan_narrow;
    out.pkt.data_valid = use_wide ? ~wide_cred_only_i : ~narrow_cred_only_i;
    out.pkt.cred_hdr   = cred_sel;
    out.pkt.credits    = (cred_sel == chan_wide) ? wide_pending_i : narrow_pending_i;
    if (!out.pkt.data_valid) begin
      out.pkt.data = '0;
    end else if (use_wide) begin
      out.pkt.data = wide_data_i;
    end else begin
      out.pkt.data = {{(WideWidth-NarrowWidth){1'b0}}, narrow_data_i};
    end
  end

  // hold the wide grant while its packet waits for the buffer
  assign sel_d = (use_wide & wide_valid_i & ~out.ready) ? chan_wide : chan_narrow;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q <= chan_narrow;
    end else begin
      sel_q <= sel_d;
    end
  end

endmodule

// File: src/vc_axis_out_buffer.sv
`timescale 1ns/1ns
// two-entry output FIFO and packing of the head packet into AXIS fields
module vc_axis_out_buffer (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  vc_pkt_if.dst                                  in,
  output logic                                   tvalid_o,
  input  logic                                   tready_i,
  output logic [vc_bridge_pkg::WideWidth:0]      tdata_o,
  output logic [vc_bridge_pkg::WideWidth/8-1:0]  tstrb_o,
  output logic [vc_bridge_pkg::CredWidth+1:0]    tuser_o
);
  import vc_bridge_pkg::*;

  bridge_pkt_t mem_q [2];
  bridge_pkt_t head;
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  logic [1:0]  count_q;
  logic        push;
  logic        pop;

  assign in.ready = (count_q != 2'd2);
  assign tvalid_o = (count_q != 2'd0);
  assign push     = in.valid & in.ready;
  assign pop      = tvalid_o & tready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in.pkt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  // AXIS view of the head entry
  assign head    = mem_q[rd_ptr_q];
  assign tdata_o = {head.data, head.data_hdr};
  assign tstrb_o = (head.data_hdr == chan_wide) ? WideStrb : NarrowStrb;
  assign tuser_o = {head.data_valid, head.cred_hdr, head.credits};

endmodule

// File: src/vc_rx_queue.sv
`timescale 1ns/1ns
// circular receive FIFO for one channel, sized to the channel's credit count
module vc_rx_queue #(
  parameter type data_t = logic,
  parameter int  Depth  = vc_bridge_pkg::NumCred
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  push_i,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o,
  output logic  pop_o
);

  localparam int AddrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth  = $clog2(Depth + 1);

  data_t                mem_q [Depth];
  logic [AddrWidth-1:0] wr_ptr_q;
  logic [AddrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0]  count_q;

  // the remote sender never exceeds its credits so the queue never overflows
  assign valid_o = (count_q != '0);
  assign pop_o   = valid_o & ready_i;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == AddrWidth'(Depth-1)) ? '0 : wr_ptr_q + AddrWidth'(1);
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == AddrWidth'(Depth-1)) ? '0 : rd_ptr_q + AddrWidth'(1);
      end
      count_q <= count_q + CntWidth'(push_i) - CntWidth'(pop_o);
    end
  end

endmodule

// File: src/vc_axis_bridge.sv
`timescale 1ns/1ns
// top level of the NoC to AXI-Stream bridge with narrow and wide virtual channels
module vc_axis_bridge #(
  parameter int NumCred         = vc_bridge_pkg::NumCred,
  parameter int ForceSendThresh = vc_bridge_pkg::ForceSendThresh
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // local flits towards the stream
  input  logic                                  narrow_valid_i,
  output logic                                  narrow_ready_o,
  input  vc_bridge_pkg::narrow_data_t           narrow_data_i,
  input  logic                                  wide_valid_i,
  output logic                                  wide_ready_o,
  input  vc_bridge_pkg::wide_data_t             wide_data_i,
  // local flits from the stream
  output logic                                  narrow_valid_o,
  input  logic                                  narrow_ready_i,
  output vc_bridge_pkg::narrow_data_t           narrow_data_o,
  output logic                                  wide_valid_o,
  input  logic                                  wide_ready_i,
  output vc_bridge_pkg::wide_data_t             wide_data_o,
  // outgoing AXIS
  output logic                                  axis_out_tvalid_o,
  input  logic                                  axis_out_tready_i,
  output logic [vc_bridge_pkg::WideWidth:0]     axis_out_tdata_o,
  output logic [vc_bridge_pkg::WideWidth/8-1:0] axis_out_tstrb_o,
  output logic [vc_bridge_pkg::CredWidth+1:0]   axis_out_tuser_o,
  // incoming AXIS with no back-pressure
  input  logic                                  axis_in_tvalid_i,
  input  logic [vc_bridge_pkg::WideWidth:0]     axis_in_tdata_i,
  input  logic [vc_bridge_pkg::CredWidth+1:0]   axis_in_tuser_i
);
  import vc_bridge_pkg::*;

  logic         n_send_valid, n_send_ready, n_cred_only, n_take, n_pop;
  logic         w_send_valid, w_send_ready, w_cred_only, w_take, w_pop;
  narrow_data_t n_send_data;
  wide_data_t   w_send_data;
  credit_t      n_pending, w_pending;
  bridge_pkt_t  rx_pkt;
  logic         n_push, w_push, n_cred_rx, w_cred_rx;

  vc_pkt_if tx_pkt ();

  //////////////////////////////////////////////////
  // outbound path

  vc_credit_tracker #(
    .data_t(narrow_data_t), .NumCred(NumCred), .ForceSendThresh(ForceSendThresh)
  ) u_narrow_tracker (
    .clk_i, .rst_n_i,
    .valid_i(narrow_valid_i), .ready_o(narrow_ready_o), .data_i(narrow_data_i),
    .send_valid_o(n_send_valid), .send_ready_i(n_send_ready),
    .data_o(n_send_data), .cred_only_o(n_cred_only),
    .cred_rx_valid_i(n_cred_rx), .cred_rx_i(rx_pkt.credits),
    .pop_i(n_pop), .pending_o(n_pending), .pending_take_i(n_take)
  );

  vc_credit_tracker #(
    .data_t(wide_data_t), .NumCred(NumCred), .ForceSendThresh(ForceSendThresh)
  ) u_wide_tracker (
    .clk_i, .rst_n_i,
    .valid_i(wide_valid_i), .ready_o(wide_ready_o), .data_i(wide_data_i),
    .send_valid_o(w_send_valid), .send_ready_i(w_send_ready),
    .data_o(w_send_data), .cred_only_o(w_cred_only),
    .cred_rx_valid_i(w_cred_rx), .cred_rx_i(rx_pkt.credits),
    .pop_i(w_pop), .pending_o(w_pending), .pending_take_i(w_take)
  );

  vc_tx_arbiter u_arbiter (
    .clk_i, .rst_n_i,
    .narrow_valid_i(n_send_valid), .narrow_ready_o(n_send_ready),
    .narrow_data_i(n_send_data), .narrow_cred_only_i(n_cred_only),
    .narrow_pending_i(n_pending), .narrow_take_o(n_take),
    .wide_valid_i(w_send_valid), .wide_ready_o(w_send_ready),
    .wide_data_i(w_send_data), .wide_cred_only_i(w_cred_only),
    .wide_pending_i(w_pending), .wide_take_o(w_take),
    .out(tx_pkt)
  );

  vc_axis_out_buffer u_out_buffer (
    .clk_i, .rst_n_i, .in(tx_pkt),
    .tvalid_o(axis_out_tvalid_o), .tready_i(axis_out_tready_i),
    .tdata_o(axis_out_tdata_o), .tstrb_o(axis_out_tstrb_o), .tuser_o(axis_out_tuser_o)
  );

  //////////////////////////////////////////////////
  // inbound path

  always_comb begin
    rx_pkt.data_hdr   = chan_e'(axis_in_tdata_i[0]);
    rx_pkt.data       = axis_in_tdata_i[WideWidth:1];
    rx_pkt.data_valid = axis_in_tuser_i[CredWidth+1];
    rx_pkt.cred_hdr   = chan_e'(axis_in_tuser_i[CredWidth]);
    rx_pkt.credits    = axis_in_tuser_i[CredWidth-1:0];
  end

  // credits ride on every beat and data only when flagged
  assign n_cred_rx = axis_in_tvalid_i & (rx_pkt.cred_hdr == chan_narrow);
  assign w_cred_rx = axis_in_tvalid_i & (rx_pkt.cred_hdr == chan_wide);
  assign n_push = axis_in_tvalid_i & rx_pkt.data_valid & (rx_pkt.data_hdr == chan_narrow);
  assign w_push = axis_in_tvalid_i & rx_pkt.data_valid & (rx_pkt.data_hdr == chan_wide);

  vc_rx_queue #(.data_t(narrow_data_t), .Depth(NumCred)) u_narrow_queue (
    .clk_i, .rst_n_i, .push_i(n_push), .data_i(rx_pkt.data[NarrowWidth-1:0]),
    .valid_o(narrow_valid_o), .ready_i(narrow_ready_i), .data_o(narrow_data_o),
    .pop_o(n_pop)
  );

  vc_rx_queue #(.data_t(wide_data_t), .Depth(NumCred)) u_wide_queue (
    .clk_i, .rst_n_i, .push_i(w_push), .data_i(rx_pkt.data),
    .valid_o(wide_valid_o), .ready_i(wide_ready_i), .data_o(wide_data_o),
    .pop_o(w_pop)
  );

endmodule

// File: test/tb_vc_axis_bridge.sv
`timescale 1ns/1ns
// vc_axis_bridge testbench with clock, reset, file-driven stimulus, scoreboard and watchdog
module tb_vc_axis_bridge;
  import vc_bridge_pkg::*;

  localparam int MaxRec = 128;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   narrow_valid_i, narrow_ready_o;
  logic [NarrowWidth-1:0] narrow_data_i;
  logic                   wide_valid_i, wide_ready_o;
  logic [WideWidth-1:0]   wide_data_i;
  logic                   narrow_valid_o, narrow_ready_i;
  logic [NarrowWidth-1:0] narrow_data_o;
  logic                   wide_valid_o, wide_ready_i;
  logic [WideWidth-1:0]   wide_data_o;
  logic                   axis_out_tvalid_o, axis_out_tready_i;
  logic [WideWidth:0]     axis_out_tdata_o;
  logic [WideWidth/8-1:0] axis_out_tstrb_o;
  logic [CredWidth+1:0]   axis_out_tuser_o;
  logic                   axis_in_tvalid_i;
  logic [WideWidth:0]     axis_in_tdata_i;
  logic [CredWidth+1:0]   axis_in_tuser_i;

  // parsed records and expected traffic
  logic [63:0] rec_op [MaxRec];
  logic [63:0] rec_v  [MaxRec][5];
  int          nrec;
  logic        loaded;
  logic [63:0] exp_narrow[$];
  logic [63:0] exp_wide[$];
  logic [63:0] exp_cred[$];
  logic [63:0] exp_rx_narrow[$];
  logic [63:0] exp_rx_wide[$];

  int          errors;
  int          pkts;
  int          cred_sum [2];
  int          pop_count [2];
  logic        stall_en;
  integer      seed;
  logic        held;
  logic [71:0] held_beat;

  vc_axis_bridge dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // helpers

  task automatic check(input string what, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int value_count(input logic [63:0] op);
    case (op)
      "D":       return 0;
      "R", "EC": return 2;
      "I":       return 5;
      default:   return 1;
    endcase
  endfunction

  // idle outputs once reset is released
  task automatic check_reset_state();
    @(negedge clk_i);
    check("narrow ready after reset", 72'(narrow_ready_o), 72'd1);
    check("wide ready after reset", 72'(wide_ready_o), 72'd1);
    check("axis_out valid after reset", 72'(axis_out_tvalid_o), 72'd0);
    check("narrow valid after reset", 72'(narrow_valid_o), 72'd0);
    check("wide valid after reset", 72'(wide_valid_o), 72'd0);
  endtask

  task automatic send_narrow(input logic [NarrowWidth-1:0] data);
    @(posedge clk_i);
    #10;
    narrow_valid_i = 1'b1;
    narrow_data_i  = data;
    @(negedge clk_i);
    while (!narrow_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #10;
    narrow_valid_i = 1'b0;
  endtask

  task automatic send_wide(input logic [WideWidth-1:0] data);
    @(posedge clk_i);
    #10;
    wide_valid_i = 1'b1;
    wide_data_i  = data;
    @(negedge clk_i);
    while (!wide_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #10;
    wide_valid_i = 1'b0;
  endtask

  // offer a narrow flit that must not be accepted for lack of credits
  task automatic probe_no_credit(input int cycles);
    @(posedge clk_i);
    #10;
    narrow_valid_i = 1'b1;
    narrow_data_i  = 32'hdead_beef;
    repeat (cycles) begin
      @(negedge clk_i);
      check("narrow ready without credits", 72'(narrow_ready_o), 72'd0);
    end
    @(posedge clk_i);
    #10;
    narrow_valid_i = 1'b0;
  endtask

  task automatic axis_in_beat(input int r);
    @(posedge clk_i);
    #10;
    axis_in_tvalid_i = 1'b1;
    axis_in_tdata_i  = {rec_v[r][1], rec_v[r][0][0]};
    axis_in_tuser_i  = {rec_v[r][2][0], rec_v[r][3][0], rec_v[r][4][CredWidth-1:0]};
    @(posedge clk_i);
    #10;
    axis_in_tvalid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_narrow.size() + exp_wide.size() + exp_cred.size() +
           exp_rx_narrow.size() + exp_rx_wide.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // output stall pattern

  always @(posedge clk_i) begin
    #10;
    if (stall_en) begin
      axis_out_tready_i = (($random(seed) & 3) != 0);
    end else begin
      axis_out_tready_i = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // scoreboard sampled mid-cycle where all inputs are settled

  always @(negedge clk_i) begin : axis_out_monitor
    logic hdr;
    if (rst_n_i) begin
      if (held) begin
        check("axis_out beat under back-pressure",
              {axis_out_tvalid_o, axis_out_tuser_o, axis_out_tdata_o}, held_beat);
      end
      held      = axis_out_tvalid_o & ~axis_out_tready_i;
      held_beat = {1'b1, axis_out_tuser_o, axis_out_tdata_o};
      if (axis_out_tvalid_o && axis_out_tready_i) begin
        pkts++;
        cred_sum[axis_out_tuser_o[CredWidth]] += int'(axis_out_tuser_o[CredWidth-1:0]);
        hdr = axis_out_tdata_o[0];
        if (axis_out_tuser_o[CredWidth+1]) begin
          check("strobe", 72'(axis_out_tstrb_o), hdr ? 72'hFF : 72'h0F);
          if (!hdr && exp_narrow.size() == 0) begin
            errors++;
            $display("unexpected narrow packet on axis_out at %0t ns", $time);
          end else if (hdr && exp_wide.size() == 0) begin
            errors++;
            $display("unexpected wide packet on axis_out at %0t ns", $time);
          end else if (!hdr) begin
            check("narrow packet data", 72'(axis_out_tdata_o[WideWidth:1]),
                  72'(exp_narrow.pop_front()));
          end else begin
            check("wide packet data", 72'(axis_out_tdata_o[WideWidth:1]),
                  72'(exp_wide.pop_front()));
          end
        end else if (exp_cred.size() == 0) begin
          errors++;
          $display("unexpected credits-only packet on axis_out at %0t ns", $time);
        end else begin
          check("credits-only user field", 72'(axis_out_tuser_o[CredWidth:0]),
                72'(exp_cred.pop_front()));
        end
      end
    end
  end

  always @(negedge clk_i) begin : local_out_monitor
    if (rst_n_i && narrow_valid_o && narrow_ready_i) begin
      pop_count[0]++;
      if (exp_rx_narrow.size() == 0) begin
        errors++;
        $display("unexpected narrow flit from the receive queue at %0t ns", $time);
      end else begin
        check("narrow received data", 72'(narrow_data_o), 72'(exp_rx_narrow.pop_front()));
      end
    end
    if (rst_n_i && wide_valid_o && wide_ready_i) begin
      pop_count[1]++;
      if (exp_rx_wide.size() == 0) begin
        errors++;
        $display("unexpected wide flit from the receive queue at %0t ns", $time);
      end else begin
        check("wide received data", 72'(wide_data_o), 72'(exp_rx_wide.pop_front()));
      end
    end
  end

  //////////////////////////////////////////////////
  // watchdog

  initial begin
    wait (loaded);
    repeat (nrec * 40) @(posedge clk_i);
    $display("watchdog expired before the test sequence completed");
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int          fd;
    int          rc;
    int          n;
    logic [63:0] tok;
    logic [63:0] val;
    logic [8*256-1:0] line;
    narrow_valid_i = 1'b0;
    narrow_data_i = '0;
    wide_valid_i = 1'b0;
    wide_data_i = '0;
    narrow_ready_i = 1'b1;
    wide_ready_i = 1'b1;
    axis_out_tready_i = 1'b1;
    axis_in_tvalid_i = 1'b0;
    axis_in_tdata_i = '0;
    axis_in_tuser_i = '0;
    rst_n_i = 1'b0;
    stall_en = 1'b0;
    seed = 32'he194_5b5c;
    held = 1'b0;
    held_beat = '0;
    errors = 0;
    pkts = 0;
    cred_sum = '{0, 0};
    pop_count = '{0, 0};
    nrec = 0;
    loaded = 1'b0;
    fd = $fopen("test/vc_bridge_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("TEST FAILED");
      $finish;
    end else begin
      while (!$feof(fd) && nrec < MaxRec) begin
        tok = '0;
        rc = $fscanf(fd, "%s", tok);
        if (rc == 1 && tok == "#") begin
          rc = $fgets(line, fd);
        end else if (rc == 1) begin
          rec_op[nrec] = tok;
          n = value_count(tok);
          for (int i = 0; i < n; i++) begin
            rc = $fscanf(fd, "%h", val);
            rec_v[nrec][i] = val;
          end
          nrec++;
        end
      end
      $fclose(fd);
      loaded = 1'b1;

      repeat (5) @(posedge clk_i);
      #10;
      rst_n_i = 1'b1;
      check_reset_state();

      for (int r = 0; r < nrec; r++) begin
        case (rec_op[r])
          "N":  send_narrow(rec_v[r][0][NarrowWidth-1:0]);
          "W":  send_wide(rec_v[r][0]);
          "I":  axis_in_beat(r);
          "B":  probe_no_credit(int'(rec_v[r][0]));
          "D":  drain();
          "Z":  repeat (int'(rec_v[r][0])) @(posedge clk_i);
          "S":  stall_en = rec_v[r][0][0];
          "EN": exp_narrow.push_back(rec_v[r][0]);
          "EW": exp_wide.push_back(rec_v[r][0]);
          "EC": exp_cred.push_back({rec_v[r][0][0], rec_v[r][1][CredWidth-1:0]});
          "XN": exp_rx_narrow.push_back(rec_v[r][0]);
          "XW": exp_rx_wide.push_back(rec_v[r][0]);
          "R": begin
            @(posedge clk_i);
            #10;
            narrow_ready_i = rec_v[r][0][0];
            wide_ready_i   = rec_v[r][1][0];
          end
          default: begin
            errors++;
            $display("unknown record in the test data file at index %0d", r);
          end
        endcase
      end
      drain();
      repeat (4) @(posedge clk_i);

      // every popped flit must have been reported back as a credit
      check("narrow credits returned", 72'(cred_sum[0]), 72'(pop_count[0]));
      check("wide credits returned", 72'(cred_sum[1]), 72'(pop_count[1]));

      $display("errors: %0d, axis_out packets: %0d, flits popped: %0d narrow %0d wide",
               errors, pkts, pop_count[0], pop_count[1]);
      if (errors == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// File: test/vc_bridge_testdata.txt
# columns: op then hex values. N data, W data, I data_hdr data data_valid cred_hdr credits
# R narrow_rdy wide_rdy, S stall, Z idle cycles, B probe cycles, D drain, EN EW XN XW data, EC cred_hdr credits
R 1 1
EN 11111111
EN 22222222
EN 33333333
EW aaaa0000bbbb0001
EW aaaa0000bbbb0002
EW aaaa0000bbbb0003
N 11111111
W aaaa0000bbbb0001
N 22222222
W aaaa0000bbbb0002
N 33333333
W aaaa0000bbbb0003
D
# narrow runs out of credits
EN 44444444
EN 55555555
EN 66666666
EN 77777777
EN 88888888
N 44444444
N 55555555
N 66666666
N 77777777
N 88888888
D
B 6
I 0 0 0 0 8
EN 99999999
N 99999999
D
# received flits and credits-only returns
XN a1
XN a2
XN a3
XN a4
EC 0 4
I 0 a1 1 0 0
I 0 a2 1 0 0
I 0 a3 1 0 0
I 0 a4 1 0 0
D
XW 1234567800000001
XW 1234567800000002
XW 1234567800000003
XW 1234567800000004
EC 1 4
I 1 1234567800000001 1 0 0
I 1 1234567800000002 1 0 0
I 1 1234567800000003 1 0 0
I 1 1234567800000004 1 0 0
D
# random back-pressure on axis_out
S 1
EN c0c0c0c1
EW 0f0f0f0f0f0f0f01
EN c0c0c0c2
EW 0f0f0f0f0f0f0f02
EN c0c0c0c3
EW 0f0f0f0f0f0f0f03
EN c0c0c0c4
N c0c0c0c1
W 0f0f0f0f0f0f0f01
N c0c0c0c2
W 0f0f0f0f0f0f0f02
N c0c0c0c3
W 0f0f0f0f0f0f0f03
N c0c0c0c4
D
S 0
# pending credits ride on a data packet
XN b1
XN b2
I 0 b1 1 0 0
I 0 b2 1 0 0
Z 4
EN d1d1d1d1
N d1d1d1d1
D

// File: verilog.f
src/vc_bridge_pkg.sv
src/vc_pkt_if.sv
src/vc_credit_tracker.sv
src/vc_tx_arbiter.sv
src/vc_axis_out_buffer.sv
src/vc_rx_queue.sv
src/vc_axis_bridge.sv
test/tb_vc_axis_bridge.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bridge testbench with Verilator, result decided from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vc_axis_bridge \
  -f verilog.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
